/* verilog/rv_decode_pkg.sv */
package rv_decode_pkg;

    localparam int XLEN        = 64;
    localparam int PC_W        = 48;
    localparam int ILEN        = 32;
    localparam int QUEUE_DEPTH = 4;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

    // major opcodes
    localparam logic [6:0] OPCODE_LUI            = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC          = 7'b0010111;
    localparam logic [6:0] OPCODE_JAL            = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR           = 7'b1100111;
    localparam logic [6:0] OPCODE_BRANCH         = 7'b1100011;
    localparam logic [6:0] OPCODE_LOAD           = 7'b0000011;
    localparam logic [6:0] OPCODE_STORE          = 7'b0100011;
    localparam logic [6:0] OPCODE_ALU_ITYPE      = 7'b0010011;
    localparam logic [6:0] OPCODE_ALU_RTYPE      = 7'b0110011;
    localparam logic [6:0] OPCODE_ALU_ITYPE_WORD = 7'b0011011;
    localparam logic [6:0] OPCODE_ALU_RTYPE_WORD = 7'b0111011;

    // bit positions in alu_type
    localparam int ALU_ADD   = 0;
    localparam int ALU_SUB   = 1;
    localparam int ALU_SLL   = 2;
    localparam int ALU_SLT   = 3;
    localparam int ALU_XOR   = 4;
    localparam int ALU_SRL   = 5;
    localparam int ALU_SRA   = 6;
    localparam int ALU_OR    = 7;
    localparam int ALU_AND   = 8;
    localparam int ALU_LUI   = 9;
    localparam int ALU_AUIPC = 10;

    // bit positions in cx_type
    localparam int CX_JAL  = 0;
    localparam int CX_JALR = 1;
    localparam int CX_BEQ  = 2;
    localparam int CX_BNE  = 3;
    localparam int CX_BLT  = 4;
    localparam int CX_BGE  = 5;

    // bit positions in ls_size
    localparam int LS_B = 0;
    localparam int LS_H = 1;
    localparam int LS_W = 2;
    localparam int LS_D = 3;

    typedef logic [4:0] reg_idx_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fields_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fields_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fields_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fields_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fields_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fields_t;

    // one instruction word, seen through each encoding
    typedef union packed {
        logic [ILEN-1:0] raw;
        r_fields_t       r;
        i_fields_t       i;
        s_fields_t       s;
        b_fields_t       b;
        u_fields_t       u;
        j_fields_t       j;
    } instr_word_u;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_t;

    typedef struct packed {
        logic [PC_W-1:0] pc;
        instr_word_u     instr;
    } fetch_entry_t;

    typedef struct packed {
        logic        src1_is_reg;
        logic        src2_is_reg;
        logic        need_to_wb;
        logic [5:0]  cx_type;
        logic        is_unsigned;
        logic [10:0] alu_type;
        logic        is_word;
        logic        is_imm;
        logic        is_load;
        logic        is_store;
        logic [3:0]  ls_size;
    } uop_ctrl_t;

    typedef struct packed {
        logic [PC_W-1:0] pc;
        reg_idx_t        rs1;
        reg_idx_t        rs2;
        reg_idx_t        rd;
        logic [XLEN-1:0] imm;
        uop_ctrl_t       ctrl;
    } decoded_uop_t;

endpackage

/* verilog/instr_queue.sv */
`timescale 1ns/100ps

module instr_queue (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        fetch_valid,
    output logic                        fetch_ready,
    input  rv_decode_pkg::fetch_entry_t fetch,
    output logic                        q_valid,
    input  logic                        q_ready,
    output rv_decode_pkg::fetch_entry_t q_entry
);
    import rv_decode_pkg::*;

    fetch_entry_t           mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   push;
    logic                   pop;

    assign fetch_ready = (count < QUEUE_CNT_W'(QUEUE_DEPTH));
    assign q_valid     = (count != '0);
    // oldest entry always on the output
    assign q_entry     = mem[rd_ptr];

    assign push = fetch_valid && fetch_ready;
    assign pop  = q_valid && q_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= fetch;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* verilog/op_decode.sv */
`timescale 1ns/100ps

module op_decode (
    input  rv_decode_pkg::instr_word_u instr,
    output rv_decode_pkg::uop_ctrl_t   ctrl,
    output rv_decode_pkg::imm_fmt_t    imm_fmt
);
    import rv_decode_pkg::*;

    logic rd_nz;

    // x0 destination never writes back
    assign rd_nz = |instr.r.rd;

    always_comb begin
        ctrl    = '0;
        imm_fmt = IMM_NONE;
        case (instr.r.opcode)
            OPCODE_LUI: begin
                imm_fmt                = IMM_U;
                ctrl.alu_type[ALU_LUI] = 1'b1;
                ctrl.need_to_wb        = rd_nz;
            end
            OPCODE_AUIPC: begin
                imm_fmt                  = IMM_U;
                ctrl.alu_type[ALU_AUIPC] = 1'b1;
                ctrl.need_to_wb          = rd_nz;
            end
            OPCODE_JAL: begin
                imm_fmt               = IMM_J;
                ctrl.cx_type[CX_JAL] = 1'b1;
                ctrl.need_to_wb       = rd_nz;
            end
            OPCODE_JALR: begin
                imm_fmt                = IMM_I;
                ctrl.cx_type[CX_JALR] = 1'b1;
                ctrl.need_to_wb        = rd_nz;
                ctrl.src1_is_reg       = 1'b1;
            end
            OPCODE_BRANCH: begin
                ctrl.src1_is_reg = 1'b1;
                ctrl.src2_is_reg = 1'b1;
                case (instr.r.funct3)
                    3'b000:  ctrl.cx_type[CX_BEQ] = 1'b1;
                    3'b001:  ctrl.cx_type[CX_BNE] = 1'b1;
                    3'b100:  ctrl.cx_type[CX_BLT] = 1'b1;
                    3'b101:  ctrl.cx_type[CX_BGE] = 1'b1;
                    3'b110:  ctrl.cx_type[CX_BLT] = 1'b1;
                    3'b111:  ctrl.cx_type[CX_BGE] = 1'b1;
                    default: ;
                endcase
                // bltu / bgeu
                ctrl.is_unsigned = instr.r.funct3[2] & instr.r.funct3[1];
                if (|ctrl.cx_type) begin
                    imm_fmt = IMM_B;
                end
            end
            OPCODE_LOAD: begin
                imm_fmt          = IMM_I;
                ctrl.is_load     = 1'b1;
                ctrl.need_to_wb  = rd_nz;
                ctrl.src1_is_reg = 1'b1;
                case (instr.r.funct3)
                    3'b000:  ctrl.ls_size[LS_B] = 1'b1;
                    3'b001:  ctrl.ls_size[LS_H] = 1'b1;
                    3'b010:  ctrl.ls_size[LS_W] = 1'b1;
                    3'b011:  ctrl.ls_size[LS_D] = 1'b1;
                    3'b100:  ctrl.ls_size[LS_B] = 1'b1;
                    3'b101:  ctrl.ls_size[LS_H] = 1'b1;
                    3'b110:  ctrl.ls_size[LS_W] = 1'b1;
                    default: ;
                endcase
                // lbu, lhu, lwu
                ctrl.is_unsigned = instr.r.funct3[2] & (instr.r.funct3[1:0] != 2'b11);
            end
            OPCODE_STORE: begin
                imm_fmt          = IMM_S;
                ctrl.is_store    = 1'b1;
                ctrl.src1_is_reg = 1'b1;
                ctrl.src2_is_reg = 1'b1;
                case (instr.r.funct3)
                    3'b000:  ctrl.ls_size[LS_B] = 1'b1;
                    3'b001:  ctrl.ls_size[LS_H] = 1'b1;
                    3'b010:  ctrl.ls_size[LS_W] = 1'b1;
                    3'b011:  ctrl.ls_size[LS_D] = 1'b1;
                    default: ;
                endcase
            end
            OPCODE_ALU_ITYPE: begin
                imm_fmt          = IMM_I;
                ctrl.need_to_wb  = rd_nz;
                ctrl.src1_is_reg = 1'b1;
                // funct7[0] is shamt[5] on rv64
                casez ({instr.r.funct7, instr.r.funct3})
                    10'b???????000: ctrl.alu_type[ALU_ADD] = 1'b1;
                    10'b???????010: ctrl.alu_type[ALU_SLT] = 1'b1;
                    10'b???????011: begin
                        ctrl.alu_type[ALU_SLT] = 1'b1;
                        ctrl.is_unsigned       = 1'b1;
                    end
                    10'b???????100: ctrl.alu_type[ALU_XOR] = 1'b1;
                    10'b???????110: ctrl.alu_type[ALU_OR]  = 1'b1;
                    10'b???????111: ctrl.alu_type[ALU_AND] = 1'b1;
                    10'b000000?001: ctrl.alu_type[ALU_SLL] = 1'b1;
                    10'b000000?101: ctrl.alu_type[ALU_SRL] = 1'b1;
                    10'b010000?101: ctrl.alu_type[ALU_SRA] = 1'b1;
                    default: ;
                endcase
                ctrl.is_imm = |ctrl.alu_type;
            end
            OPCODE_ALU_RTYPE: begin
                ctrl.need_to_wb  = rd_nz;
                ctrl.src1_is_reg = 1'b1;
                ctrl.src2_is_reg = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                    10'b0000000000: ctrl.alu_type[ALU_ADD] = 1'b1;
                    10'b0100000000: ctrl.alu_type[ALU_SUB] = 1'b1;
                    10'b0000000001: ctrl.alu_type[ALU_SLL] = 1'b1;
                    10'b0000000010: ctrl.alu_type[ALU_SLT] = 1'b1;
                    10'b0000000011: begin
                        ctrl.alu_type[ALU_SLT] = 1'b1;
                        ctrl.is_unsigned       = 1'b1;
                    end
                    10'b0000000100: ctrl.alu_type[ALU_XOR] = 1'b1;
                    10'b0000000101: ctrl.alu_type[ALU_SRL] = 1'b1;
                    10'b0100000101: ctrl.alu_type[ALU_SRA] = 1'b1;
                    10'b0000000110: ctrl.alu_type[ALU_OR]  = 1'b1;
                    10'b0000000111: ctrl.alu_type[ALU_AND] = 1'b1;
                    default: ;
                endcase
            end
            OPCODE_ALU_ITYPE_WORD: begin
                imm_fmt          = IMM_I;
                ctrl.is_word     = 1'b1;
                ctrl.need_to_wb  = rd_nz;
                ctrl.src1_is_reg = 1'b1;
                casez ({instr.r.funct7, instr.r.funct3})
                    10'b???????000: ctrl.alu_type[ALU_ADD] = 1'b1;
                    10'b0000000001: ctrl.alu_type[ALU_SLL] = 1'b1;
                    10'b0000000101: ctrl.alu_type[ALU_SRL] = 1'b1;
                    10'b0100000101: ctrl.alu_type[ALU_SRA] = 1'b1;
                    default: ;
                endcase
                ctrl.is_imm = |ctrl.alu_type;
            end
            OPCODE_ALU_RTYPE_WORD: begin
                ctrl.is_word     = 1'b1;
                ctrl.need_to_wb  = rd_nz;
                ctrl.src1_is_reg = 1'b1;
                ctrl.src2_is_reg = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                    10'b0000000000: ctrl.alu_type[ALU_ADD] = 1'b1;
                    10'b0100000000: ctrl.alu_type[ALU_SUB] = 1'b1;
                    10'b0000000001: ctrl.alu_type[ALU_SLL] = 1'b1;
                    10'b0000000101: ctrl.alu_type[ALU_SRL] = 1'b1;
                    10'b0100000101: ctrl.alu_type[ALU_SRA] = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* verilog/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen (
    input  rv_decode_pkg::instr_word_u       instr,
    input  rv_decode_pkg::imm_fmt_t          imm_fmt,
    output logic [rv_decode_pkg::XLEN-1:0]   imm
);
    import rv_decode_pkg::*;

    always_comb begin
        case (imm_fmt)
            IMM_I: begin
                imm = {{(XLEN - 12){instr.i.imm_11_0[11]}}, instr.i.imm_11_0};
            end
            IMM_S: begin
                imm = {{(XLEN - 12){instr.s.imm_11_5[6]}}, instr.s.imm_11_5,
                       instr.s.imm_4_0};
            end
            // bit 0 of branch and jump offsets is implied zero
            IMM_B: begin
                imm = {{(XLEN - 13){instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11,
                       instr.b.imm_10_5, instr.b.imm_4_1, 1'b0};
            end
            IMM_U: begin
                imm = {{(XLEN - 32){instr.u.imm_31_12[19]}}, instr.u.imm_31_12, 12'b0};
            end
            IMM_J: begin
                imm = {{(XLEN - 21){instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12,
                       instr.j.imm_11, instr.j.imm_10_1, 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

/* verilog/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        q_valid,
    output logic                        q_ready,
    input  rv_decode_pkg::fetch_entry_t q_entry,
    output logic                        dec_valid,
    input  logic                        dec_ready,
    output rv_decode_pkg::decoded_uop_t dec_uop
);
    import rv_decode_pkg::*;

    uop_ctrl_t       ctrl;
    imm_fmt_t        imm_fmt;
    logic [XLEN-1:0] imm;
    decoded_uop_t    uop_next;

    op_decode op_decode_inst (
        .instr   (q_entry.instr),
        .ctrl    (ctrl),
        .imm_fmt (imm_fmt)
    );

    imm_gen imm_gen_inst (
        .instr   (q_entry.instr),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    assign uop_next.pc   = q_entry.pc;
    assign uop_next.rs1  = q_entry.instr.r.rs1;
    assign uop_next.rs2  = q_entry.instr.r.rs2;
    assign uop_next.rd   = q_entry.instr.r.rd;
    assign uop_next.imm  = imm;
    assign uop_next.ctrl = ctrl;

    // take a new entry when the output slot is free or draining
    assign q_ready = !dec_valid || dec_ready;

    always_ff @(posedge clock) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (q_ready) begin
            dec_valid <= q_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (q_valid && q_ready) begin
            dec_uop <= uop_next;
        end
    end

endmodule

/* verilog/decoder_top.sv */
`timescale 1ns/100ps

module decoder_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        fetch_valid,
    output logic                        fetch_ready,
    input  rv_decode_pkg::fetch_entry_t fetch,
    output logic                        dec_valid,
    input  logic                        dec_ready,
    output rv_decode_pkg::decoded_uop_t dec_uop
);
    import rv_decode_pkg::*;

    logic         q_valid;
    logic         q_ready;
    fetch_entry_t q_entry;

    instr_queue instr_queue_inst (
        .clock       (clock),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .q_valid     (q_valid),
        .q_ready     (q_ready),
        .q_entry     (q_entry)
    );

    decode_stage decode_stage_inst (
        .clock     (clock),
        .reset     (reset),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_entry   (q_entry),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_uop   (dec_uop)
    );

endmodule

/* tb/decoder_props.sv */
`timescale 1ns/100ps

module decoder_props (
    input logic                        clock,
    input logic                        reset,
    input logic                        fetch_valid,
    input logic                        fetch_ready,
    input rv_decode_pkg::fetch_entry_t fetch,
    input logic                        dec_valid,
    input logic                        dec_ready,
    input rv_decode_pkg::decoded_uop_t dec_uop
);

    // a waiting sender keeps valid and data
    fetch_held: assert property (@(posedge clock) disable iff (reset)
        fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch))
        else $error("fetch entry changed while waiting for fetch_ready");

    uop_held: assert property (@(posedge clock) disable iff (reset)
        dec_valid && !dec_ready |=> dec_valid && $stable(dec_uop))
        else $error("micro-op changed while waiting for dec_ready");

    ctrl_onehot: assert property (@(posedge clock) disable iff (reset)
        dec_valid |-> $onehot0(dec_uop.ctrl.cx_type) && $onehot0(dec_uop.ctrl.alu_type)
                      && $onehot0(dec_uop.ctrl.ls_size))
        else $error("control field with more than one bit set");

    ld_st_excl: assert property (@(posedge clock) disable iff (reset)
        dec_valid |-> !(dec_uop.ctrl.is_load && dec_uop.ctrl.is_store))
        else $error("micro-op marked as both load and store");

endmodule

bind decoder_top decoder_props decoder_props_inst (
    .clock       (clock),
    .reset       (reset),
    .fetch_valid (fetch_valid),
    .fetch_ready (fetch_ready),
    .fetch       (fetch),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_uop     (dec_uop)
);

/* tb/decoder_tb.sv */
`timescale 1ns/100ps

module decoder_tb;
    import rv_decode_pkg::*;

    localparam int WAIT_LIMIT = 200;
    localparam int NUM_RANDOM = 600;

    logic         clock;
    logic         reset;
    logic         fetch_valid;
    logic         fetch_ready;
    fetch_entry_t fetch;
    logic         dec_valid;
    logic         dec_ready;
    decoded_uop_t dec_uop;

    logic [31:0]  lfsr_state;
    decoded_uop_t sb [$];
    int           completed;

    decoder_top decoder_top_inst (
        .clock       (clock),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec_uop     (dec_uop)
    );

    always #2 clock = ~clock;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic fail_now();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic abort_run(input string reason);
        $display("error at %0t: %s", $time, reason);
        fail_now();
    endtask

    task automatic check_equal(input string what, input logic [255:0] actual,
                               input logic [255:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s: got %h, expected %h", $time, what, actual, expected);
            fail_now();
        end
    endtask

    function automatic logic [63:0] imm_ref(input logic [31:0] w, input imm_fmt_t fmt);
        logic [63:0] v;
        case (fmt)
            IMM_I:   v = {{52{w[31]}}, w[31:20]};
            IMM_S:   v = {{52{w[31]}}, w[31:25], w[11:7]};
            IMM_B:   v = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            IMM_U:   v = {{32{w[31]}}, w[31:12], 12'h000};
            IMM_J:   v = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic logic [10:0] alu_onehot(input logic [2:0] f3, input logic [6:0] f7,
                                               input logic imm_form, input logic word_form);
        logic [10:0] t;
        logic        base_ok;
        logic        lsh_ok;
        logic        ash_ok;
        t = '0;
        base_ok = imm_form || (f7 == 7'h00);
        if (imm_form && !word_form) begin
            // 6-bit shamt borrows funct7 bit 0
            lsh_ok = (f7[6:1] == 6'h00);
            ash_ok = (f7[6:1] == 6'h10);
        end else begin
            lsh_ok = (f7 == 7'h00);
            ash_ok = (f7 == 7'h20);
        end
        case (f3)
            3'd0: begin
                if (base_ok) t[ALU_ADD] = 1'b1;
                else if (!imm_form && f7 == 7'h20) t[ALU_SUB] = 1'b1;
            end
            3'd1: if (lsh_ok) t[ALU_SLL] = 1'b1;
            3'd2, 3'd3: if (base_ok && !word_form) t[ALU_SLT] = 1'b1;
            3'd4: if (base_ok && !word_form) t[ALU_XOR] = 1'b1;
            3'd5: begin
                if (lsh_ok) t[ALU_SRL] = 1'b1;
                else if (ash_ok) t[ALU_SRA] = 1'b1;
            end
            3'd6: if (base_ok && !word_form) t[ALU_OR] = 1'b1;
            default: if (base_ok && !word_form) t[ALU_AND] = 1'b1;
        endcase
        return t;
    endfunction

    function automatic decoded_uop_t decode_ref(input fetch_entry_t e);
        decoded_uop_t u;
        logic [31:0]  w;
        logic [6:0]   op;
        logic [6:0]   f7;
        logic [2:0]   f3;
        logic         wb;
        imm_fmt_t     fmt;
        w   = e.instr.raw;
        op  = w[6:0];
        f3  = w[14:12];
        f7  = w[31:25];
        wb  = (w[11:7] != 5'd0);
        u   = '0;
        fmt = IMM_NONE;
        u.pc  = e.pc;
        u.rs1 = w[19:15];
        u.rs2 = w[24:20];
        u.rd  = w[11:7];
        case (op)
            OPCODE_LUI: begin
                u.ctrl.alu_type[ALU_LUI] = 1'b1;
                u.ctrl.need_to_wb = wb;
                fmt = IMM_U;
            end
            OPCODE_AUIPC: begin
                u.ctrl.alu_type[ALU_AUIPC] = 1'b1;
                u.ctrl.need_to_wb = wb;
                fmt = IMM_U;
            end
            OPCODE_JAL: begin
                u.ctrl.cx_type[CX_JAL] = 1'b1;
                u.ctrl.need_to_wb = wb;
                fmt = IMM_J;
            end
            OPCODE_JALR: begin
                u.ctrl.cx_type[CX_JALR] = 1'b1;
                u.ctrl.need_to_wb = wb;
                u.ctrl.src1_is_reg = 1'b1;
                fmt = IMM_I;
            end
            OPCODE_BRANCH: begin
                u.ctrl.src1_is_reg = 1'b1;
                u.ctrl.src2_is_reg = 1'b1;
                if (f3 != 3'd2 && f3 != 3'd3) begin
                    fmt = IMM_B;
                    case (f3)
                        3'd0:       u.ctrl.cx_type[CX_BEQ] = 1'b1;
                        3'd1:       u.ctrl.cx_type[CX_BNE] = 1'b1;
                        3'd4, 3'd6: u.ctrl.cx_type[CX_BLT] = 1'b1;
                        default:    u.ctrl.cx_type[CX_BGE] = 1'b1;
                    endcase
                    u.ctrl.is_unsigned = (f3 == 3'd6 || f3 == 3'd7);
                end
            end
            OPCODE_LOAD: begin
                u.ctrl.is_load = 1'b1;
                u.ctrl.need_to_wb = wb;
                u.ctrl.src1_is_reg = 1'b1;
                fmt = IMM_I;
                if (f3 != 3'd7) begin
                    u.ctrl.ls_size = 4'b0001 << f3[1:0];
                    u.ctrl.is_unsigned = f3[2];
                end
            end
            OPCODE_STORE: begin
                u.ctrl.is_store = 1'b1;
                u.ctrl.src1_is_reg = 1'b1;
                u.ctrl.src2_is_reg = 1'b1;
                fmt = IMM_S;
                if (!f3[2]) u.ctrl.ls_size = 4'b0001 << f3[1:0];
            end
            OPCODE_ALU_ITYPE, OPCODE_ALU_ITYPE_WORD: begin
                u.ctrl.is_word = (op == OPCODE_ALU_ITYPE_WORD);
                u.ctrl.need_to_wb = wb;
                u.ctrl.src1_is_reg = 1'b1;
                fmt = IMM_I;
                u.ctrl.alu_type = alu_onehot(f3, f7, 1'b1, u.ctrl.is_word);
                u.ctrl.is_imm = |u.ctrl.alu_type;
                u.ctrl.is_unsigned = (f3 == 3'd3) && u.ctrl.alu_type[ALU_SLT];
            end
            OPCODE_ALU_RTYPE, OPCODE_ALU_RTYPE_WORD: begin
                u.ctrl.is_word = (op == OPCODE_ALU_RTYPE_WORD);
                u.ctrl.need_to_wb = wb;
                u.ctrl.src1_is_reg = 1'b1;
                u.ctrl.src2_is_reg = 1'b1;
                u.ctrl.alu_type = alu_onehot(f3, f7, 1'b0, u.ctrl.is_word);
                u.ctrl.is_unsigned = (f3 == 3'd3) && u.ctrl.alu_type[ALU_SLT];
            end
            default: ;
        endcase
        u.imm = imm_ref(w, fmt);
        return u;
    endfunction

    function automatic fetch_entry_t random_entry();
        fetch_entry_t e;
        logic [6:0]   op;
        logic [6:0]   f7;
        logic [4:0]   rd;
        case (rand_bits(8) % 12)
            0:  op = OPCODE_LUI;
            1:  op = OPCODE_AUIPC;
            2:  op = OPCODE_JAL;
            3:  op = OPCODE_JALR;
            4:  op = OPCODE_BRANCH;
            5:  op = OPCODE_LOAD;
            6:  op = OPCODE_STORE;
            7:  op = OPCODE_ALU_ITYPE;
            8:  op = OPCODE_ALU_RTYPE;
            9:  op = OPCODE_ALU_ITYPE_WORD;
            10: op = OPCODE_ALU_RTYPE_WORD;
            default: begin
                op = {5'(rand_bits(5)), 2'b11};
                // fence stands in for a known opcode
                if (op inside {OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR,
                               OPCODE_BRANCH, OPCODE_LOAD, OPCODE_STORE, OPCODE_ALU_ITYPE,
                               OPCODE_ALU_RTYPE, OPCODE_ALU_ITYPE_WORD,
                               OPCODE_ALU_RTYPE_WORD}) begin
                    op = 7'b0001111;
                end
            end
        endcase
        f7 = 7'(rand_bits(7));
        if (rand_bits(2) != 0) begin
            if (op == OPCODE_ALU_ITYPE) begin
                f7 = {1'b0, 1'(rand_bits(1)), 4'b0000, 1'(rand_bits(1))};
            end else if (op inside {OPCODE_ALU_RTYPE, OPCODE_ALU_RTYPE_WORD,
                                    OPCODE_ALU_ITYPE_WORD}) begin
                f7 = {1'b0, 1'(rand_bits(1)), 5'b00000};
            end
        end
        if (rand_bits(3) == 0) rd = '0;
        else rd = 5'(rand_bits(5));
        e.pc = {16'(rand_bits(16)), rand_bits(32)};
        e.instr.raw = {f7, 5'(rand_bits(5)), 5'(rand_bits(5)), 3'(rand_bits(3)), rd, op};
        return e;
    endfunction

    // outputs are checked before new fetches are queued
    always @(posedge clock) begin
        decoded_uop_t expected;
        if (!reset) begin
            if (dec_valid && dec_ready) begin
                if (sb.size() == 0) begin
                    abort_run("decoded output with no fetch waiting for it");
                end else begin
                    expected = sb.pop_front();
                    completed++;
                    if (expected.rd == 5'd0) begin
                        check_equal("need_to_wb for x0", 256'(dec_uop.ctrl.need_to_wb), 256'(0));
                    end
                    check_equal("imm", 256'(dec_uop.imm), 256'(expected.imm));
                    check_equal("ctrl", 256'(dec_uop.ctrl), 256'(expected.ctrl));
                    check_equal("uop", 256'(dec_uop), 256'(expected));
                end
            end
            if (fetch_valid && fetch_ready) begin
                sb.push_back(decode_ref(fetch));
            end
        end
    end

    // called on a falling edge with fetch_valid up; returns on the transfer edge
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        while (!fetch_ready) begin
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("fetch handshake never completed");
            @(negedge clock);
        end
        @(posedge clock);
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (sb.size() != 0 || dec_valid) begin
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("pipeline did not drain");
            @(negedge clock);
        end
    endtask

    initial begin
        int cycles;
        int count;
        int sent;
        logic stalled;
        logic pending;
        clock       = 1'b0;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        dec_ready   = 1'b0;
        lfsr_state  = 32'h7b90;
        completed   = 0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        check_equal("dec_valid after reset", 256'(dec_valid), 256'(0));
        check_equal("fetch_ready after reset", 256'(fetch_ready), 256'(1));

        // single fetch through an idle pipeline
        dec_ready = 1'b1;
        @(negedge clock);
        fetch = random_entry();
        fetch_valid = 1'b1;
        wait_accept();
        cycles = 0;
        do begin
            @(negedge clock);
            fetch_valid = 1'b0;
            cycles++;
            if (cycles > WAIT_LIMIT) abort_run("dec_valid never rose");
        end while (!dec_valid);
        check_equal("fetch to dec_valid latency", 256'(cycles), 256'(2));
        wait_drain();

        // output stalled until the queue backs up
        dec_ready = 1'b0;
        count = 0;
        stalled = 1'b0;
        while (!stalled) begin
            @(negedge clock);
            fetch = random_entry();
            fetch_valid = 1'b1;
            if (!fetch_ready) begin
                stalled = 1'b1;
            end else begin
                @(posedge clock);
                count++;
                if (count > 2 * QUEUE_DEPTH + 2) abort_run("fetch_ready never fell");
            end
        end
        check_equal("entries taken before stall", 256'(count), 256'(QUEUE_DEPTH + 1));
        repeat (6) @(negedge clock);
        check_equal("fetch_ready during stall", 256'(fetch_ready), 256'(0));
        dec_ready = 1'b1;
        wait_accept();
        @(negedge clock);
        fetch_valid = 1'b0;
        wait_drain();

        // random traffic with random back-pressure
        sent = 0;
        pending = 1'b0;
        cycles = 0;
        while (sent < NUM_RANDOM || pending) begin
            @(negedge clock);
            cycles++;
            if (cycles > NUM_RANDOM * 16) abort_run("random traffic stopped making progress");
            if (!pending) begin
                if (sent < NUM_RANDOM && rand_bits(2) != 0) begin
                    fetch = random_entry();
                    fetch_valid = 1'b1;
                    pending = 1'b1;
                    sent++;
                end else begin
                    fetch_valid = 1'b0;
                end
            end
            dec_ready = (rand_bits(2) != 0);
            if (pending && fetch_ready) pending = 1'b0;
        end
        @(negedge clock);
        fetch_valid = 1'b0;
        dec_ready = 1'b1;
        wait_drain();

        // the single fetch, the stall burst and the entry held at the stall
        check_equal("micro-ops delivered", 256'(completed), 256'(sent + count + 2));
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* filelist.f */
verilog/rv_decode_pkg.sv
verilog/instr_queue.sv
verilog/op_decode.sv
verilog/imm_gen.sv
verilog/decode_stage.sv
verilog/decoder_top.sv
tb/decoder_props.sv
tb/decoder_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the decoder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module decoder_tb -Mdir obj_dir -o decoder_tb_sim \
    -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/decoder_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
